// ==== rtl/cache_geom_pkg.sv ====
// cache geometry shared by every cache block: sizes, field widths and address types
package cache_geom_pkg;

	// ------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------
	localparam int unsigned WORD_W         = 32;
	localparam int unsigned WORDS_PER_LINE = 4;
	localparam int unsigned LINE_W         = WORD_W * WORDS_PER_LINE;  // 128 bit line
	localparam int unsigned SETS           = 4;
	localparam int unsigned WAYS           = 2;

	// word address = tag | index | offset
	localparam int unsigned OFFSET_W = 2;
	localparam int unsigned INDEX_W  = 2;
	localparam int unsigned TAG_W    = 26;

	// ------------------------------------------------------------
	// address types
	// ------------------------------------------------------------
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;
	typedef logic [$clog2(WAYS)-1:0] way_t;

	// processor side addresses words, memory side addresses lines
	typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] word_addr_t;
	typedef logic [TAG_W+INDEX_W-1:0]          line_addr_t;

	// split of a word address, msb first
	typedef struct packed {
		tag_t    tag;
		index_t  index;
		offset_t offset;  // word within the line
	} addr_fields_t;

endpackage

// ==== rtl/cache_bus_pkg.sv ====
// bus types between processor, cache and line memory, plus the controller state encoding
package cache_bus_pkg;

	// ------------------------------------------------------------
	// one cache line
	// ------------------------------------------------------------
	// memory bus moves the flat word, the data array works per word
	typedef union packed {
		logic [cache_geom_pkg::LINE_W-1:0] flat;
		logic [cache_geom_pkg::WORDS_PER_LINE-1:0][cache_geom_pkg::WORD_W-1:0] words;  // word 0 in low bits
	} line_u;

	// ------------------------------------------------------------
	// processor request, held by the requester while stalled
	// ------------------------------------------------------------
	typedef struct packed {
		logic                              read;
		logic                              write;
		cache_geom_pkg::word_addr_t        addr;
		logic [cache_geom_pkg::WORD_W-1:0] wdata;
	} proc_req_t;

	// ------------------------------------------------------------
	// memory request, held until the ready pulse
	// ------------------------------------------------------------
	typedef struct packed {
		logic                       read;
		logic                       write;
		cache_geom_pkg::line_addr_t addr;
		line_u                      wdata;  // only meaningful on write
	} mem_req_t;

	// miss handling states
	typedef enum logic [1:0] {
		IDLE      = 2'd0,  // serving hits
		WRITEBACK = 2'd1,  // dirty victim going out
		REFILL    = 2'd2   // line coming in
	} ctrl_state_t;

endpackage

// ==== rtl/cache_tag_store.sv ====
// tag, valid, dirty and lru state of the two-way cache, with the combinational hit lookup
`timescale 1ns/1ps

module cache_tag_store (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cache_geom_pkg::word_addr_t i_addr,
	input  logic                       i_fill_en,
	input  cache_geom_pkg::way_t       i_fill_way,
	input  logic                       i_wr_en,
	input  logic                       i_touch,
	output logic                       o_hit,
	output cache_geom_pkg::way_t       o_hit_way,
	output cache_geom_pkg::way_t       o_victim_way,
	output logic                       o_victim_dirty,
	output cache_geom_pkg::tag_t       o_victim_tag
);

	cache_geom_pkg::tag_t tags [cache_geom_pkg::SETS][cache_geom_pkg::WAYS];
	logic [cache_geom_pkg::WAYS-1:0] valid [cache_geom_pkg::SETS];
	logic [cache_geom_pkg::WAYS-1:0] dirty [cache_geom_pkg::SETS];
	cache_geom_pkg::way_t lru [cache_geom_pkg::SETS];  // way to evict next

	cache_geom_pkg::addr_fields_t fields;
	cache_geom_pkg::index_t idx;
	logic [cache_geom_pkg::WAYS-1:0] way_hit;

	assign fields = i_addr;
	assign idx    = fields.index;

	// ------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
			way_hit[w] = valid[idx][w] && (tags[idx][w] == fields.tag);  // full tag compare
		end
	end

	assign o_hit = |way_hit;

	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
			if (way_hit[w])
				o_hit_way = cache_geom_pkg::way_t'(w);
		end
	end

	// empty way first, lowest one wins; else the lru pick
	always_comb begin
		o_victim_way = lru[idx];
		for (int w = cache_geom_pkg::WAYS - 1; w >= 0; w--) begin
			if (!valid[idx][w])
				o_victim_way = cache_geom_pkg::way_t'(w);
		end
	end

	assign o_victim_dirty = valid[idx][o_victim_way] && dirty[idx][o_victim_way];
	assign o_victim_tag   = tags[idx][o_victim_way];

	// ------------------------------------------------------------
	// state update
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < cache_geom_pkg::SETS; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
				lru[s]   <= '0;
			end
		end else if (i_fill_en) begin
			valid[idx][i_fill_way] <= 1'b1;
			dirty[idx][i_fill_way] <= 1'b0;  // fresh copy of memory
			lru[idx]               <= ~i_fill_way;
		end else begin
			if (i_wr_en)
				dirty[idx][o_hit_way] <= 1'b1;
			if (i_touch)
				lru[idx] <= ~o_hit_way;
		end
	end

	always_ff @(posedge clk) begin
		if (i_fill_en)
			tags[idx][i_fill_way] <= fields.tag;
	end

	// a refill only ever lands in a way that missed
	a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(way_hit) <= 1)
		else $error("tag store: address hits in more than one way");

endmodule

// ==== rtl/cache_line_store.sv ====
// data array of the cache: word read and line read, word write on hit, line write on refill
`timescale 1ns/1ps

module cache_line_store (
	input  logic                              clk,
	input  cache_geom_pkg::word_addr_t        i_addr,
	input  cache_geom_pkg::way_t              i_way,
	input  logic [cache_geom_pkg::WORD_W-1:0] i_wdata,
	input  logic                              i_wr_en,
	input  logic                              i_fill_en,
	input  cache_bus_pkg::line_u              i_fill_line,
	output logic [cache_geom_pkg::WORD_W-1:0] o_rdata,
	output cache_bus_pkg::line_u              o_line
);

	// ------------------------------------------------------------
	// storage, one line per set and way
	// ------------------------------------------------------------
	cache_bus_pkg::line_u lines [cache_geom_pkg::SETS][cache_geom_pkg::WAYS];

	cache_geom_pkg::addr_fields_t fields;
	cache_geom_pkg::index_t idx;
	cache_geom_pkg::offset_t off;

	assign fields = i_addr;
	assign idx    = fields.index;
	assign off    = fields.offset;

	// ------------------------------------------------------------
	// reads
	// ------------------------------------------------------------
	// whole line feeds the write-back path
	assign o_line = lines[idx][i_way];

	// addressed word for the processor, same cycle
	assign o_rdata = o_line.words[off];

	// ------------------------------------------------------------
	// writes
	// ------------------------------------------------------------
	// refill and hit write never share a cycle
	always_ff @(posedge clk) begin
		if (i_fill_en) begin
			lines[idx][i_way] <= i_fill_line;
		end else if (i_wr_en) begin
			lines[idx][i_way].words[off] <= i_wdata;  // merge one word into the line
		end
	end

endmodule

// ==== rtl/cache_ctrl.sv ====
// miss controller that drives stall, write-back of dirty victims, refill and the store strobes
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cache_bus_pkg::proc_req_t   i_proc,
	input  logic                       i_hit,
	input  cache_geom_pkg::way_t       i_hit_way,
	input  cache_geom_pkg::way_t       i_victim_way,
	input  logic                       i_victim_dirty,
	input  cache_geom_pkg::tag_t       i_victim_tag,
	input  cache_bus_pkg::line_u       i_line,
	input  logic                       i_mem_ready,
	output logic                       o_proc_stall,
	output cache_bus_pkg::mem_req_t    o_mem,
	output logic                       o_fill_en,
	output logic                       o_wr_en,
	output logic                       o_touch,
	output cache_geom_pkg::way_t       o_way
);

	cache_bus_pkg::ctrl_state_t state_q;
	cache_bus_pkg::ctrl_state_t state_d;
	cache_geom_pkg::addr_fields_t fields;
	logic req;
	logic idle;

	assign fields = i_proc.addr;
	assign req    = i_proc.read || i_proc.write;
	assign idle   = (state_q == cache_bus_pkg::IDLE);

	// ------------------------------------------------------------
	// state register
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= cache_bus_pkg::IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_bus_pkg::IDLE: begin
				if (req && !i_hit)  // clean victims skip the write-back
					state_d = i_victim_dirty ? cache_bus_pkg::WRITEBACK : cache_bus_pkg::REFILL;
			end
			cache_bus_pkg::WRITEBACK: begin
				if (i_mem_ready)
					state_d = cache_bus_pkg::REFILL;
			end
			cache_bus_pkg::REFILL: begin
				if (i_mem_ready)
					state_d = cache_bus_pkg::IDLE;
			end
			default: state_d = cache_bus_pkg::IDLE;
		endcase
	end

	// ------------------------------------------------------------
	// combinational outputs
	// ------------------------------------------------------------
	assign o_proc_stall = !idle || (req && !i_hit);  // busy with a miss or a new miss
	assign o_wr_en      = idle && i_hit && i_proc.write;
	assign o_touch      = idle && i_hit && req;
	assign o_fill_en    = (state_q == cache_bus_pkg::REFILL) && i_mem_ready;
	assign o_way        = i_hit ? i_hit_way : i_victim_way;

	always_comb begin
		o_mem = '0;
		case (state_q)
			cache_bus_pkg::WRITEBACK: begin
				o_mem.write = 1'b1;
				o_mem.addr  = {i_victim_tag, fields.index};  // victim's own line address
				o_mem.wdata = i_line;
			end
			cache_bus_pkg::REFILL: begin
				o_mem.read = 1'b1;
				o_mem.addr = {fields.tag, fields.index};
			end
			default: o_mem = '0;
		endcase
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(o_mem.read && o_mem.write))
		else $error("cache ctrl: mem read and write together");

	// relies on the requester holding its request while stalled
	a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(o_mem.read || o_mem.write) && !i_mem_ready |=> $stable(o_mem))
		else $error("cache ctrl: mem request changed before ready");

	a_stall_req: assert property (@(posedge clk) disable iff (!rst_n)
		o_proc_stall |-> req)
		else $error("cache ctrl: stall without a request");

endmodule

// ==== rtl/cache_top.sv ====
// two-way write-back cache between a processor word port and a line-wide slow memory
`timescale 1ns/1ps

module cache_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  cache_bus_pkg::proc_req_t          i_proc,
	input  cache_bus_pkg::line_u              i_mem_rdata,
	input  logic                              i_mem_ready,
	output logic [cache_geom_pkg::WORD_W-1:0] o_proc_rdata,
	output logic                              o_proc_stall,
	output cache_bus_pkg::mem_req_t           o_mem
);

	// ------------------------------------------------------------
	// lookup results and store strobes
	// ------------------------------------------------------------
	logic                 hit;
	cache_geom_pkg::way_t hit_way;
	cache_geom_pkg::way_t victim_way;
	logic                 victim_dirty;
	cache_geom_pkg::tag_t victim_tag;
	logic                 fill_en;
	logic                 wr_en;
	logic                 touch;
	cache_geom_pkg::way_t way;       // hit way or victim way
	cache_bus_pkg::line_u line;      // selected line for write-back

	cache_tag_store u_tag (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_addr         (i_proc.addr),
		.i_fill_en      (fill_en),
		.i_fill_way     (way),
		.i_wr_en        (wr_en),
		.i_touch        (touch),
		.o_hit          (hit),
		.o_hit_way      (hit_way),
		.o_victim_way   (victim_way),
		.o_victim_dirty (victim_dirty),
		.o_victim_tag   (victim_tag)
	);

	cache_line_store u_line (
		.clk         (clk),
		.i_addr      (i_proc.addr),
		.i_way       (way),
		.i_wdata     (i_proc.wdata),
		.i_wr_en     (wr_en),
		.i_fill_en   (fill_en),
		.i_fill_line (i_mem_rdata),
		.o_rdata     (o_proc_rdata),
		.o_line      (line)
	);

	cache_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_proc         (i_proc),
		.i_hit          (hit),
		.i_hit_way      (hit_way),
		.i_victim_way   (victim_way),
		.i_victim_dirty (victim_dirty),
		.i_victim_tag   (victim_tag),
		.i_line         (line),
		.i_mem_ready    (i_mem_ready),
		.o_proc_stall   (o_proc_stall),
		.o_mem          (o_mem),
		.o_fill_en      (fill_en),
		.o_wr_en        (wr_en),
		.o_touch        (touch),
		.o_way          (way)
	);

endmodule

// ==== verification/tb_slow_mem.sv ====
// behavioural line memory for the cache testbench: fixed latency, known fill pattern, traffic counters
`timescale 1ns/1ps

module tb_slow_mem #(
	parameter int MEM_LATENCY = 3
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cache_bus_pkg::mem_req_t    i_req,
	output cache_bus_pkg::line_u       o_rdata,
	output logic                       o_ready,
	output int                         o_rd_count,
	output int                         o_wr_count,
	output cache_geom_pkg::line_addr_t o_last_wr_addr,
	output cache_bus_pkg::line_u       o_last_wr_data
);

	localparam int MEM_LINES = 256;

	cache_bus_pkg::line_u mem [MEM_LINES];
	logic [7:0] line_idx;
	int lat_cnt;  // cycles the current request has waited

	assign line_idx = i_req.addr[7:0];

	// ------------------------------------------------------------
	// reset loads the pattern, a held request is served after the latency
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < MEM_LINES; l++) begin
				for (int w = 0; w < 4; w++)
					mem[l].words[w] <= (l * 4 + w) ^ 32'h5a5a0000;  // word address based
			end
			o_rdata        <= '0;
			o_ready        <= 1'b0;
			o_rd_count     <= 0;
			o_wr_count     <= 0;
			o_last_wr_addr <= '0;
			o_last_wr_data <= '0;
			lat_cnt        <= 0;
		end else if (o_ready) begin
			o_ready <= 1'b0;  // single cycle pulse
			lat_cnt <= 0;
		end else if (i_req.read || i_req.write) begin
			if (lat_cnt == MEM_LATENCY - 1) begin
				o_ready <= 1'b1;
				lat_cnt <= 0;
				if (i_req.write) begin
					mem[line_idx]  <= i_req.wdata;
					o_wr_count     <= o_wr_count + 1;
					o_last_wr_addr <= i_req.addr;
					o_last_wr_data <= i_req.wdata;
				end else begin
					o_rdata    <= mem[line_idx];
					o_rd_count <= o_rd_count + 1;
				end
			end else begin
				lat_cnt <= lat_cnt + 1;
			end
		end
	end

endmodule

// ==== verification/tb_cache.sv ====
// testbench top for the cache that replays the cases file against a slow memory and checks results
`timescale 1ns/1ps

module tb_cache;

	localparam int MEM_LATENCY = 3;
	localparam int SEED = 32'h0e97d89d;
	localparam string CASES_FILE = "verification/cache_cases.txt";

	logic clk;
	logic rst_n;
	cache_bus_pkg::proc_req_t proc;
	cache_bus_pkg::mem_req_t mem_req;
	cache_bus_pkg::line_u mem_rdata;
	logic mem_ready;
	logic [31:0] rdata;
	logic stall;
	int rd_count;
	int wr_count;
	cache_geom_pkg::line_addr_t last_wr_addr;
	cache_bus_pkg::line_u last_wr_data;

	// one entry per access line of the cases file
	logic [7:0] c_op [$];
	logic [31:0] c_addr [$];
	logic [31:0] c_wdata [$];
	logic [31:0] c_rdata [$];
	int c_nrd [$];
	int c_nwr [$];

	logic [31:0] shadow [int];  // words written so far by word address
	int cycles = 0;
	int cycle_limit = 0;

	cache_top i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_proc       (proc),
		.i_mem_rdata  (mem_rdata),
		.i_mem_ready  (mem_ready),
		.o_proc_rdata (rdata),
		.o_proc_stall (stall),
		.o_mem        (mem_req)
	);

	tb_slow_mem #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_req          (mem_req),
		.o_rdata        (mem_rdata),
		.o_ready        (mem_ready),
		.o_rd_count     (rd_count),
		.o_wr_count     (wr_count),
		.o_last_wr_addr (last_wr_addr),
		.o_last_wr_data (last_wr_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	// ------------------------------------------------------------
	// failure handling and checks
	// ------------------------------------------------------------
	task automatic fail_run(input string why);
		$display("test failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
			fail_run("a checked value did not match");
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			fail_run($sformatf("timeout after %0d cycles with the controller in %s",
				cycles, i_dut.u_ctrl.state_q.name()));
	end

	// last written value or else the fill pattern
	function automatic logic [31:0] expected_mem_word(input int waddr);
		if (shadow.exists(waddr))
			return shadow[waddr];
		return waddr ^ 32'h5a5a0000;
	endfunction

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic load_cases();
		int fd;
		int n;
		string text;
		logic [7:0] op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] exp_rd;
		int nrd;
		int nwr;
		fd = $fopen(CASES_FILE, "r");
		if (fd == 0)
			fail_run("could not open the cases file");
		while ($fgets(text, fd) > 0) begin
			if (text.len() < 2 || text.getc(0) == "#")  // blank or comment
				continue;
			n = $sscanf(text, "%c %h %h %h %d %d", op, addr, wdata, exp_rd, nrd, nwr);
			if (n != 6)
				fail_run("a line of the cases file could not be parsed");
			c_op.push_back(op);
			c_addr.push_back(addr);
			c_wdata.push_back(wdata);
			c_rdata.push_back(exp_rd);
			c_nrd.push_back(nrd);
			c_nwr.push_back(nwr);
		end
		$fclose(fd);
	endtask

	// no request after reset so nothing may move
	task automatic check_quiet();
		repeat (3) begin
			@(negedge clk);
			check_eq({31'd0, stall}, 32'd0, "stall while idle after reset");
			check_eq({30'd0, mem_req.read, mem_req.write}, 32'd0, "memory request while idle");
			check_eq(rd_count + wr_count, 32'd0, "memory traffic while idle");
		end
	endtask

	task automatic run_access(input int i);
		cache_bus_pkg::proc_req_t req;
		cache_geom_pkg::addr_fields_t f;
		cache_geom_pkg::addr_fields_t wb;
		int wr_before;
		int prev_nrd;
		int idle;
		req.read  = (c_op[i] == "R");
		req.write = (c_op[i] == "W");
		req.addr  = cache_geom_pkg::word_addr_t'(c_addr[i]);
		req.wdata = c_wdata[i];
		f         = req.addr;
		wr_before = wr_count;
		prev_nrd  = (i == 0) ? 0 : c_nrd[i-1];
		proc <= req;
		@(negedge clk);
		// every miss refills, so misses stall in the request cycle and hits never do
		check_eq({31'd0, stall}, {31'd0, (c_nrd[i] != prev_nrd)},
			$sformatf("case %0d stall in the request cycle", i));
		while (stall)
			@(negedge clk);
		if (req.read)
			check_eq(rdata, c_rdata[i], $sformatf("case %0d read data at %h", i, c_addr[i]));
		check_eq(rd_count, c_nrd[i], $sformatf("case %0d memory read count", i));
		check_eq(wr_count, c_nwr[i], $sformatf("case %0d memory write count", i));
		if (wr_count != wr_before) begin
			// evicted line of the same set carries every word written to it
			wb = {last_wr_addr, 2'b00};
			check_eq({30'd0, wb.index}, {30'd0, f.index}, $sformatf("case %0d write-back set", i));
			check_eq({31'd0, wb.tag != f.tag}, 32'd1, $sformatf("case %0d write-back tag", i));
			for (int w = 0; w < 4; w++)
				check_eq(last_wr_data.words[w],
					expected_mem_word(int'({last_wr_addr, 2'(w)})),
					$sformatf("case %0d write-back word %0d", i, w));
		end
		@(posedge clk);  // access completes here
		if (req.write)
			shadow[int'(c_addr[i])] = c_wdata[i];
		idle = int'($urandom % 3);
		if (idle > 0) begin
			proc <= '0;
			repeat (idle) @(posedge clk);
		end
	endtask

	initial begin
		rst_n <= 1'b0;
		proc  <= '0;
		void'($urandom(SEED));
		load_cases();
		cycle_limit = c_op.size() * (2 * MEM_LATENCY + 8) + 50;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		check_quiet();
		@(posedge clk);
		for (int i = 0; i < c_op.size(); i++)
			run_access(i);
		$display("test passed");
		$finish;
	end

endmodule

// ==== verification/cache_cases.txt ====
# op word_addr wdata expected_read mem_reads mem_writes (counts are totals after the access)
# expected_read is ignored on W lines
R 00000010 00000000 5a5a0010 1 0
R 00000013 00000000 5a5a0013 1 0
R 00000011 00000000 5a5a0011 1 0
W 00000012 deadbeef 00000000 1 0
R 00000012 00000000 deadbeef 1 0
W 00000021 12345678 00000000 2 0
R 00000021 00000000 12345678 2 0
R 00000030 00000000 5a5a0030 3 1
R 00000012 00000000 deadbeef 4 2
R 00000021 00000000 12345678 5 2
R 00000044 00000000 5a5a0044 6 2
R 00000056 00000000 5a5a0056 7 2
R 00000067 00000000 5a5a0067 8 2
R 00000055 00000000 5a5a0055 8 2
R 00000045 00000000 5a5a0045 9 2
R 00000078 00000000 5a5a0078 10 2
R 00000089 00000000 5a5a0089 11 2
R 0000007a 00000000 5a5a007a 11 2
R 00000098 00000000 5a5a0098 12 2
R 0000007b 00000000 5a5a007b 12 2
R 0000008b 00000000 5a5a008b 13 2
W 000000ac cafef00d 00000000 14 2
W 000000bd 0badc0de 00000000 15 2
R 000000ac 00000000 cafef00d 15 2
W 000000bf 600dcafe 00000000 15 2
R 000000ce 00000000 5a5a00ce 16 3
R 000000dc 00000000 5a5a00dc 17 4
R 000000af 00000000 5a5a00af 18 4
R 000000ac 00000000 cafef00d 18 4
R 000000bf 00000000 600dcafe 19 4
R 000000bd 00000000 0badc0de 19 4
W 00000013 11112222 00000000 19 4
R 00000020 00000000 5a5a0020 19 4
R 00000030 00000000 5a5a0030 20 5
R 00000013 00000000 11112222 21 5

// ==== vlog.f ====
rtl/cache_geom_pkg.sv
rtl/cache_bus_pkg.sv
rtl/cache_tag_store.sv
rtl/cache_line_store.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verification/tb_slow_mem.sv
verification/tb_cache.sv

// ==== run.sh ====
#!/bin/sh
# builds the cache testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cache -f vlog.f -o sim_cache
./obj_dir/sim_cache
